//--- list.f
comm_link_pkg.sv
credit_fifo.sv
calib_master.sv
channel_out.sv
channel_in.sv
assembler_out.sv
assembler_in.sv
comm_link.sv
tb_comm_link.sv

//--- Bender.yml
package:
  name: comm_link

sources:
  - comm_link_pkg.sv
  - credit_fifo.sv
  - calib_master.sv
  - channel_out.sv
  - channel_in.sv
  - assembler_out.sv
  - assembler_in.sv
  - comm_link.sv
  - target: test
    files:
      - tb_comm_link.sv

//--- tb_comm_link.sv
// testbench of the link endpoint with its far end looped back
// far end drops one wire and returns tokens at a random rate
// checks calibration timing, active mask, word order and credit bounds
module tb_comm_link import comm_link_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   // must match the DUT defaults
   localparam int channels_lp   = 4;
   localparam int lg_depth_lp   = 3;
   localparam int wait_lp       = 2 ** 4;
   localparam int prepare_lp    = 20;
   localparam int test_lp       = 16;
   localparam int depth_lp      = 2 ** lg_depth_lp;
   localparam int n_words_lp    = 400;
   localparam int timeout_lp    = 10 + wait_lp + prepare_lp + test_lp + n_words_lp * 20;
   localparam logic [31:0] seed_lp = 32'hd5eb6f9a;

   // set bit = wire intact, channel 2 is cut
   localparam logic [channels_lp-1:0] live_mask_lp = 4'b1011;

   logic                         io_master_clk_i = 1'b0;
   logic                         rst_i;
   core_msg_t                    core_in_i;
   logic                         core_ready_o;
   core_msg_t                    core_out_o;
   logic                         core_yumi_i;
   chan_flit_t [channels_lp-1:0] link_out_o;
   logic [channels_lp-1:0]       link_token_i;
   chan_flit_t [channels_lp-1:0] link_in_i;
   logic [channels_lp-1:0]       link_token_o;
   logic                         slave_reset_o;
   logic                         calib_done_o;
   logic [channels_lp-1:0]       channel_active_o;

   logic [31:0] lfsr_q = seed_lp;
   core_word_t  sb_q [$];
   int          words_in = 0;
   int          words_out = 0;
   int          cyc_idx = 0;
   logic        done_q = 1'b0;
   int          pend [channels_lp];
   int          sent [channels_lp];
   int          returned [channels_lp];
   int          test_seen = 0;

   always
   begin
      #50 io_master_clk_i = ~io_master_clk_i;
   end

   comm_link i_dut (
      .io_master_clk_i  (io_master_clk_i),
      .rst_i            (rst_i),
      .core_in_i        (core_in_i),
      .core_ready_o     (core_ready_o),
      .core_out_o       (core_out_o),
      .core_yumi_i      (core_yumi_i),
      .link_out_o       (link_out_o),
      .link_token_i     (link_token_i),
      .link_in_i        (link_in_i),
      .link_token_o     (link_token_o),
      .slave_reset_o    (slave_reset_o),
      .calib_done_o     (calib_done_o),
      .channel_active_o (channel_active_o)
   );

   // 32 bit fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit taken
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
   endtask

   task automatic fail_now(input string msg);
      $display("ERR %0t %s", $time, msg);
      $display("Errors found");
      $fatal(1, "stopped at first error");
   endtask

   // ************************************************************
   // far end: straight wire loopback, cut channel never valid
   // ************************************************************
   always_comb
   begin
      for (int c = 0; c < channels_lp; c++)
      begin
         link_in_i[c].valid = link_out_o[c].valid & live_mask_lp[c];
         link_in_i[c].data  = link_out_o[c].data;
      end
   end

   // ************************************************************
   // stimulus: core words, yumi back-pressure, delayed tokens
   // ************************************************************
   always @(posedge io_master_clk_i)
   begin
      logic [31:0] r;
      logic [31:0] w;
      logic        rel;
      if (rst_i)
      begin
         core_in_i    <= '0;
         core_yumi_i  <= 1'b0;
         link_token_i <= '0;
         for (int c = 0; c < channels_lp; c++)
         begin
            pend[c] = 0;
         end
      end
      else
      begin
         if (core_in_i.valid && core_ready_o)
         begin
            words_in++;
         end
         // a word is held until it is taken
         if (!core_in_i.valid || core_ready_o)
         begin
            take_bits(1, r);
            take_bits(32, w);
            if (words_in < n_words_lp)
            begin
               core_in_i <= '{valid: r[0], word: w};
            end
            else
            begin
               core_in_i <= '0;
            end
         end
         // yumi only where valid is certain next cycle
         take_bits(1, r);
         core_yumi_i <= core_out_o.valid & ~core_yumi_i & r[0];
         // tokens queue up per channel, released at random
         take_bits(channels_lp, r);
         for (int c = 0; c < channels_lp; c++)
         begin
            rel             = (pend[c] != 0) & r[c];
            link_token_i[c] <= rel;
            pend[c]         = pend[c] + int'(link_token_o[c]) - int'(rel);
         end
      end
   end

   // ************************************************************
   // checks, sampled at the edge where the DUT samples
   // ************************************************************
   always @(posedge io_master_clk_i)
   begin
      core_word_t exp_word;
      logic       exp_prep;
      logic       exp_done;
      if (rst_i)
      begin
         cyc_idx = 0;
         done_q  = 1'b0;
         for (int c = 0; c < channels_lp; c++)
         begin
            sent[c]     = 0;
            returned[c] = 0;
         end
      end
      else
      begin
         // calibration phases counted from the fall of reset
         exp_prep = (cyc_idx >= wait_lp) && (cyc_idx < wait_lp + prepare_lp);
         exp_done = (cyc_idx >= wait_lp + prepare_lp + test_lp);
         assert (slave_reset_o === exp_prep)
         else fail_now($sformatf("slave_reset_o %b, expected %b in cycle %0d",
                                 slave_reset_o, exp_prep, cyc_idx));
         assert (calib_done_o === exp_done)
         else fail_now($sformatf("calib_done_o %b, expected %b in cycle %0d",
                                 calib_done_o, exp_done, cyc_idx));
         if (!calib_done_o)
         begin
            assert (core_ready_o === 1'b0 && core_out_o.valid === 1'b0)
            else fail_now("core side active before calibration done");
            assert (link_token_o === '0)
            else fail_now($sformatf("link_token_o %b before calibration done", link_token_o));
         end
         // pattern flits start one cycle into the test window
         if (cyc_idx <= wait_lp + prepare_lp)
         begin
            for (int c = 0; c < channels_lp; c++)
            begin
               assert (link_out_o[c].valid === 1'b0)
               else fail_now($sformatf("link_out_o[%0d] valid in cycle %0d", c, cyc_idx));
            end
         end
         if (calib_done_o)
         begin
            assert (channel_active_o === live_mask_lp)
            else fail_now($sformatf("channel_active_o %b, expected %b",
                                    channel_active_o, live_mask_lp));
         end
         // scoreboard in acceptance order
         if (core_in_i.valid && core_ready_o)
         begin
            sb_q.push_back(core_in_i.word);
         end
         if (core_out_o.valid && core_yumi_i)
         begin
            assert (sb_q.size() > 0)
            else fail_now("word popped from core_out_o with none outstanding");
            exp_word = sb_q.pop_front();
            assert (core_out_o.word === exp_word)
            else fail_now($sformatf("word %0d is %h, expected %h",
                                    words_out, core_out_o.word, exp_word));
            words_out++;
         end
         // credit window and silent dead channel once data flows
         for (int c = 0; c < channels_lp; c++)
         begin
            if (done_q && link_out_o[c].valid)
            begin
               sent[c]++;
            end
            if (link_token_i[c])
            begin
               returned[c]++;
            end
            assert (sent[c] - returned[c] <= depth_lp && returned[c] <= sent[c])
            else fail_now($sformatf("channel %0d has %0d flits outstanding",
                                    c, sent[c] - returned[c]));
            if (done_q && !live_mask_lp[c])
            begin
               assert (link_out_o[c].valid === 1'b0)
               else fail_now($sformatf("dead channel %0d sent a flit", c));
            end
         end
         if (i_dut.i_calib.state_q == st_test)
         begin
            test_seen++;
         end
         cyc_idx++;
         done_q = calib_done_o;
      end
   end

   // ************************************************************
   // run control and watchdog
   // ************************************************************
   initial
   begin
      rst_i        = 1'b1;
      core_in_i    = '0;
      core_yumi_i  = 1'b0;
      link_token_i = '0;
      repeat (10) @(posedge io_master_clk_i);
      rst_i <= 1'b0;
      wait (words_out == n_words_lp);
      repeat (10) @(posedge io_master_clk_i);
      $display("calibration test state seen for %0d cycles", test_seen);
      if (sb_q.size() == 0 && words_in == n_words_lp && words_out == n_words_lp)
      begin
         $display("No errors");
         $finish;
      end
      else
      begin
         fail_now($sformatf("%0d words in, %0d out, %0d left in scoreboard",
                            words_in, words_out, sb_q.size()));
      end
   end

   initial
   begin
      repeat (timeout_lp) @(posedge io_master_clk_i);
      $display("timeout: only %0d of %0d words came back within %0d cycles",
               words_out, n_words_lp, timeout_lp);
      $display("Errors found");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- comm_link.sv
// top of the master side link endpoint
// calibration sequencer, per channel in/out pairs and both assemblers
module comm_link import comm_link_pkg::*; #(
   parameter int link_channels_p  = 4,
   parameter int lg_fifo_depth_p  = 3,
   parameter int lg_wait_cycles_p = 4,
   parameter int prepare_cycles_p = 20,
   parameter int test_cycles_p    = 16
) (
   input  logic                             io_master_clk_i,
   input  logic                             rst_i,
   input  core_msg_t                        core_in_i,
   output logic                             core_ready_o,
   output core_msg_t                        core_out_o,
   input  logic                             core_yumi_i,
   output chan_flit_t [link_channels_p-1:0] link_out_o,
   input  logic [link_channels_p-1:0]       link_token_i,
   input  chan_flit_t [link_channels_p-1:0] link_in_i,
   output logic [link_channels_p-1:0]       link_token_o,
   output logic                             slave_reset_o,
   output logic                             calib_done_o,
   output logic [link_channels_p-1:0]       channel_active_o
);

   logic                             prepare;
   logic                             test_en;
   logic                             done;
   logic [link_channels_p-1:0]       active;
   logic [link_channels_p-1:0]       out_ready;
   logic [link_channels_p-1:0]       pop;
   chan_flit_t [link_channels_p-1:0] snoop;
   chan_flit_t [link_channels_p-1:0] asm_flit;
   chan_flit_t [link_channels_p-1:0] head;

   // prepare pulse doubles as the far side reset
   assign slave_reset_o    = prepare;
   assign calib_done_o     = done;
   assign channel_active_o = active;

   calib_master #(
      .link_channels_p  (link_channels_p),
      .lg_wait_cycles_p (lg_wait_cycles_p),
      .prepare_cycles_p (prepare_cycles_p),
      .test_cycles_p    (test_cycles_p)
   ) i_calib (
      .io_master_clk_i (io_master_clk_i),
      .rst_i           (rst_i),
      .snoop_i         (snoop),
      .prepare_o       (prepare),
      .test_en_o       (test_en),
      .active_o        (active),
      .done_o          (done)
   );

   for (genvar i = 0; i < link_channels_p; i++)
   begin : g_ch
      channel_out #(
         .lg_fifo_depth_p (lg_fifo_depth_p)
      ) i_out (
         .io_master_clk_i (io_master_clk_i),
         .rst_i           (rst_i),
         .prepare_i       (prepare),
         .test_en_i       (test_en),
         .flit_i          (asm_flit[i]),
         .ready_o         (out_ready[i]),
         .token_i         (link_token_i[i]),
         .link_o          (link_out_o[i])
      );

      channel_in #(
         .lg_fifo_depth_p (lg_fifo_depth_p)
      ) i_in (
         .io_master_clk_i (io_master_clk_i),
         .rst_i           (rst_i),
         .test_en_i       (test_en),
         .link_i          (link_in_i[i]),
         .head_o          (head[i]),
         .pop_i           (pop[i]),
         .token_o         (link_token_o[i]),
         .snoop_o         (snoop[i])
      );
   end

   assembler_out #(
      .link_channels_p (link_channels_p)
   ) i_asm_out (
      .io_master_clk_i (io_master_clk_i),
      .rst_i           (rst_i),
      .done_i          (done),
      .active_i        (active),
      .core_in_i       (core_in_i),
      .core_ready_o    (core_ready_o),
      .flit_o          (asm_flit),
      .ready_i         (out_ready)
   );

   assembler_in #(
      .link_channels_p (link_channels_p)
   ) i_asm_in (
      .io_master_clk_i (io_master_clk_i),
      .rst_i           (rst_i),
      .done_i          (done),
      .active_i        (active),
      .head_i          (head),
      .pop_o           (pop),
      .core_out_o      (core_out_o),
      .core_yumi_i     (core_yumi_i)
   );

endmodule

//--- assembler_in.sv
// merges flits from the active channels back into core words
// follows the same rotation rule as the output assembler
module assembler_in import comm_link_pkg::*; #(
   parameter int link_channels_p = 4
) (
   input  logic                             io_master_clk_i,
   input  logic                             rst_i,
   input  logic                             done_i,
   input  logic [link_channels_p-1:0]       active_i,
   input  chan_flit_t [link_channels_p-1:0] head_i,
   output logic [link_channels_p-1:0]       pop_o,
   output core_msg_t                        core_out_o,
   input  logic                             core_yumi_i
);

   localparam int ptr_w_lp = (link_channels_p > 1) ? $clog2(link_channels_p) : 1;
   localparam int idx_w_lp = (core_channels_c > 1) ? $clog2(core_channels_c) : 1;

   logic                take;
   logic                last_flit;
   logic                full_q;
   core_word_t          word_q;
   logic [ptr_w_lp-1:0] ptr_q;
   logic [idx_w_lp-1:0] idx_q;

   // stall while a finished word waits for yumi
   assign take      = done_i & ~full_q & active_i[ptr_q] & head_i[ptr_q].valid;
   assign last_flit = (idx_q == idx_w_lp'(core_channels_c - 1));

   always_comb
   begin
      for (int c = 0; c < link_channels_p; c++)
      begin
         pop_o[c] = take & (ptr_q == ptr_w_lp'(c));
      end
   end

   assign core_out_o = '{valid: full_q & done_i, word: word_q};

   always_ff @(posedge io_master_clk_i)
   begin
      if (take)
      begin
         word_q[idx_q*channel_width_c +: channel_width_c] <= head_i[ptr_q].data;
      end
   end

   always_ff @(posedge io_master_clk_i)
   begin
      if (rst_i | ~done_i)
      begin
         ptr_q  <= ptr_w_lp'(link_channels_p - 1);
         idx_q  <= '0;
         full_q <= 1'b0;
      end
      else
      begin
         if (take | ~active_i[ptr_q])
         begin
            ptr_q <= ptr_w_lp'(next_active_f(ptr_q, 32'(active_i), link_channels_p));
         end
         if (take)
         begin
            idx_q <= last_flit ? '0 : idx_q + 1'b1;
         end
         // take and yumi never meet, take needs an empty slot
         if (take & last_flit)
         begin
            full_q <= 1'b1;
         end
         else if (core_yumi_i)
         begin
            full_q <= 1'b0;
         end
      end
   end

endmodule

//--- assembler_out.sv
// splits buffered core words into flits
// one flit per cycle to the pointed channel, rotating over the active mask
module assembler_out import comm_link_pkg::*; #(
   parameter int link_channels_p = 4
) (
   input  logic                             io_master_clk_i,
   input  logic                             rst_i,
   input  logic                             done_i,
   input  logic [link_channels_p-1:0]       active_i,
   input  core_msg_t                        core_in_i,
   output logic                             core_ready_o,
   output chan_flit_t [link_channels_p-1:0] flit_o,
   input  logic [link_channels_p-1:0]       ready_i
);

   localparam int ptr_w_lp = (link_channels_p > 1) ? $clog2(link_channels_p) : 1;
   localparam int idx_w_lp = (core_channels_c > 1) ? $clog2(core_channels_c) : 1;

   logic                full;
   logic                word_v;
   core_word_t          word;
   logic                issue;
   logic                last_flit;
   chan_data_t          chunk;
   logic [ptr_w_lp-1:0] ptr_q;
   logic [idx_w_lp-1:0] idx_q;

   // two entry word buffer, nothing enters before calibration is done
   credit_fifo #(
      .lg_depth_p (1),
      .payload_t  (core_word_t)
   ) i_buf (
      .io_master_clk_i (io_master_clk_i),
      .rst_i           (rst_i),
      .clear_i         (~done_i),
      .wdata_i         (core_in_i.word),
      .wvalid_i        (core_in_i.valid & core_ready_o),
      .full_o          (full),
      .rdata_o         (word),
      .rvalid_o        (word_v),
      .pop_i           (issue & last_flit)
   );

   assign core_ready_o = done_i & ~full;

   assign issue     = done_i & word_v & active_i[ptr_q] & ready_i[ptr_q];
   assign last_flit = (idx_q == idx_w_lp'(core_channels_c - 1));
   assign chunk     = word[idx_q*channel_width_c +: channel_width_c];

   always_comb
   begin
      for (int c = 0; c < link_channels_p; c++)
      begin
         flit_o[c].valid = issue & (ptr_q == ptr_w_lp'(c));
         flit_o[c].data  = chunk;
      end
   end

   // pointer parks on the top channel, then steps to the next active one
   // on every issue or whenever it sits on a dead channel
   always_ff @(posedge io_master_clk_i)
   begin
      if (rst_i | ~done_i)
      begin
         ptr_q <= ptr_w_lp'(link_channels_p - 1);
         idx_q <= '0;
      end
      else
      begin
         if (issue | ~active_i[ptr_q])
         begin
            ptr_q <= ptr_w_lp'(next_active_f(ptr_q, 32'(active_i), link_channels_p));
         end
         if (issue)
         begin
            idx_q <= last_flit ? '0 : idx_q + 1'b1;
         end
      end
   end

endmodule

//--- channel_in.sv
// one input channel: receive FIFO, token return, snoop register
// writes are blocked and the FIFO held empty while calibration flits arrive
module channel_in import comm_link_pkg::*; #(
   parameter int lg_fifo_depth_p = 3
) (
   input  logic       io_master_clk_i,
   input  logic       rst_i,
   input  logic       test_en_i,
   input  chan_flit_t link_i,
   output chan_flit_t head_o,
   input  logic       pop_i,
   output logic       token_o,
   output chan_flit_t snoop_o
);

   logic       test_q;
   logic       block;
   logic       wr;
   logic       full;
   logic       rvalid;
   chan_data_t rdata;
   logic       token_q;
   chan_flit_t snoop_q;

   // last pattern flit leaves the output register one cycle after test
   always_ff @(posedge io_master_clk_i)
   begin
      if (rst_i)
      begin
         test_q <= 1'b0;
      end
      else
      begin
         test_q <= test_en_i;
      end
   end

   assign block = test_en_i | test_q;
   assign wr    = link_i.valid & ~block;

   credit_fifo #(
      .lg_depth_p (lg_fifo_depth_p),
      .payload_t  (chan_data_t)
   ) i_fifo (
      .io_master_clk_i (io_master_clk_i),
      .rst_i           (rst_i),
      .clear_i         (block),
      .wdata_i         (link_i.data),
      .wvalid_i        (wr),
      .full_o          (full),
      .rdata_o         (rdata),
      .rvalid_o        (rvalid),
      .pop_i           (pop_i)
   );

   assign head_o = '{valid: rvalid, data: rdata};

   // one token per popped flit, a cycle later
   always_ff @(posedge io_master_clk_i)
   begin
      if (rst_i)
      begin
         token_q      <= 1'b0;
         snoop_q.valid <= 1'b0;
      end
      else
      begin
         token_q      <= pop_i & rvalid;
         snoop_q.valid <= link_i.valid;
      end
   end

   always_ff @(posedge io_master_clk_i)
   begin
      snoop_q.data <= link_i.data;
   end

   assign token_o = token_q;
   assign snoop_o = snoop_q;

   // far side spends a credit per flit, so space is always there
   a_no_overflow : assert property (@(posedge io_master_clk_i) disable iff (rst_i)
      wr |-> !full);

endmodule

//--- channel_out.sv
// one output channel: credit counter and registered link flit
// sends the calibration pattern during the test window, silent in prepare
module channel_out import comm_link_pkg::*; #(
   parameter int lg_fifo_depth_p = 3
) (
   input  logic       io_master_clk_i,
   input  logic       rst_i,
   input  logic       prepare_i,
   input  logic       test_en_i,
   input  chan_flit_t flit_i,
   output logic       ready_o,
   input  logic       token_i,
   output chan_flit_t link_o
);

   localparam int start_lp = 2 ** lg_fifo_depth_p;

   logic [lg_fifo_depth_p:0] credit_q;
   logic                     send;
   chan_flit_t               link_q;

   // no data while calibration owns the wires
   assign ready_o = (credit_q != '0) & ~prepare_i & ~test_en_i;
   assign send    = flit_i.valid & ready_o;
   assign link_o  = link_q;

   // held at the start value through prepare and test
   // calibration flits are not credited, the far end drops them
   always_ff @(posedge io_master_clk_i)
   begin
      if (rst_i | prepare_i | test_en_i)
      begin
         credit_q <= (lg_fifo_depth_p+1)'(start_lp);
      end
      else
      begin
         credit_q <= credit_q + (lg_fifo_depth_p+1)'(token_i)
                              - (lg_fifo_depth_p+1)'(send);
      end
   end

   always_ff @(posedge io_master_clk_i)
   begin
      if (rst_i)
      begin
         link_q.valid <= 1'b0;
      end
      else
      begin
         link_q.valid <= test_en_i | send;
      end
   end

   always_ff @(posedge io_master_clk_i)
   begin
      if (test_en_i)
      begin
         link_q.data <= calib_pattern_c;
      end
      else if (send)
      begin
         link_q.data <= flit_i.data;
      end
   end

   // far end returns at most one token per flit it received
   a_credit_bound : assert property (@(posedge io_master_clk_i) disable iff (rst_i)
      credit_q <= (lg_fifo_depth_p+1)'(start_lp));

endmodule

//--- calib_master.sv
// calibration sequencer: wait after reset, prepare pulse, test window
// judges every input channel from its snoop flit and builds the active mask
module calib_master import comm_link_pkg::*; #(
   parameter int link_channels_p  = 4,
   parameter int lg_wait_cycles_p = 4,
   parameter int prepare_cycles_p = 20,
   parameter int test_cycles_p    = 16
) (
   input  logic                              io_master_clk_i,
   input  logic                              rst_i,
   input  chan_flit_t [link_channels_p-1:0]  snoop_i,
   output logic                              prepare_o,
   output logic                              test_en_o,
   output logic [link_channels_p-1:0]        active_o,
   output logic                              done_o
);

   localparam int wait_lp  = 2 ** lg_wait_cycles_p;
   localparam int span_lp  = (wait_lp > prepare_cycles_p) ? wait_lp : prepare_cycles_p;
   localparam int max_lp   = (span_lp > test_cycles_p) ? span_lp : test_cycles_p;
   localparam int cnt_w_lp = (max_lp > 1) ? $clog2(max_lp) : 1;

   calib_state_e               state_q;
   logic [cnt_w_lp-1:0]        cnt_q;
   logic                       last;
   logic [link_channels_p-1:0] seen_q;
   logic [link_channels_p-1:0] wrong_q;
   logic [link_channels_p-1:0] active_q;

   // ************************************************************
   // phase sequencing
   // ************************************************************

   // last cycle of the current phase
   always_comb
   begin
      case (state_q)
         st_wait:    last = (cnt_q == cnt_w_lp'(wait_lp - 1));
         st_prepare: last = (cnt_q == cnt_w_lp'(prepare_cycles_p - 1));
         st_test:    last = (cnt_q == cnt_w_lp'(test_cycles_p - 1));
         default:    last = 1'b0;
      endcase
   end

   always_ff @(posedge io_master_clk_i)
   begin
      if (rst_i)
      begin
         state_q <= st_wait;
         cnt_q   <= '0;
      end
      else if (last)
      begin
         cnt_q <= '0;
         case (state_q)
            st_wait:    state_q <= st_prepare;
            st_prepare: state_q <= st_test;
            default:    state_q <= st_done;
         endcase
      end
      else if (state_q != st_done)
      begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // ************************************************************
   // per channel judgement
   // ************************************************************

   // seen: pattern arrived at least once, wrong: any other valid data
   always_ff @(posedge io_master_clk_i)
   begin
      if (rst_i | prepare_o)
      begin
         seen_q  <= '0;
         wrong_q <= '0;
      end
      else if (state_q == st_test)
      begin
         for (int c = 0; c < link_channels_p; c++)
         begin
            if (snoop_i[c].valid)
            begin
               if (snoop_i[c].data == calib_pattern_c)
               begin
                  seen_q[c] <= 1'b1;
               end
               else
               begin
                  wrong_q[c] <= 1'b1;
               end
            end
         end
      end
   end

   // mask is latched once, as the test window closes
   always_ff @(posedge io_master_clk_i)
   begin
      if (rst_i)
      begin
         active_q <= '0;
      end
      else if ((state_q == st_test) && last)
      begin
         active_q <= seen_q & ~wrong_q;
      end
   end

   assign prepare_o = (state_q == st_prepare);
   assign test_en_o = (state_q == st_test);
   assign done_o    = (state_q == st_done);
   assign active_o  = active_q;

   // far side reset runs its full length and hands over to the test window
   a_prepare_len : assert property (@(posedge io_master_clk_i) disable iff (rst_i)
      $rose(prepare_o) |-> prepare_o [*prepare_cycles_p] ##1 test_en_o);

   // both assemblers rely on a frozen mask after calibration
   a_active_stable : assert property (@(posedge io_master_clk_i) disable iff (rst_i)
      done_o |=> $stable(active_o));

endmodule

//--- credit_fifo.sv
// synchronous FIFO on a circular buffer
// read/write pointers plus an occupancy count, payload given as a type
module credit_fifo #(
   parameter int  lg_depth_p = 3,
   parameter type payload_t  = logic
) (
   input  logic     io_master_clk_i,
   input  logic     rst_i,
   input  logic     clear_i,
   input  payload_t wdata_i,
   input  logic     wvalid_i,
   output logic     full_o,
   output payload_t rdata_o,
   output logic     rvalid_o,
   input  logic     pop_i
);

   localparam int depth_lp = 2 ** lg_depth_p;

   payload_t              mem_q [depth_lp];
   logic [lg_depth_p-1:0] wptr_q;
   logic [lg_depth_p-1:0] rptr_q;
   logic [lg_depth_p:0]   count_q;
   logic                  do_wr;
   logic                  do_rd;

   assign full_o   = (count_q == (lg_depth_p+1)'(depth_lp));
   assign rvalid_o = (count_q != '0);
   assign rdata_o  = mem_q[rptr_q];

   // a write into a full buffer is dropped here, callers guard against it
   assign do_wr = wvalid_i & ~full_o;
   assign do_rd = pop_i & rvalid_o;

   always_ff @(posedge io_master_clk_i)
   begin
      if (do_wr)
      begin
         mem_q[wptr_q] <= wdata_i;
      end
   end

   // pointers wrap naturally at the power of two depth
   always_ff @(posedge io_master_clk_i)
   begin
      if (rst_i | clear_i)
      begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         count_q <= '0;
      end
      else
      begin
         if (do_wr)
         begin
            wptr_q <= wptr_q + 1'b1;
         end
         if (do_rd)
         begin
            rptr_q <= rptr_q + 1'b1;
         end
         count_q <= count_q + (lg_depth_p+1)'(do_wr) - (lg_depth_p+1)'(do_rd);
      end
   end

endmodule

//--- comm_link_pkg.sv
// shared widths and flit/word types of the link endpoint
// calibration state type and the channel rotation helper
package comm_link_pkg;

   // data bits carried by one channel flit
   localparam int channel_width_c = 8;
   // flits per core word
   localparam int core_channels_c = 4;

   typedef logic [channel_width_c-1:0] chan_data_t;

   // one link wire group
   typedef struct packed {
      logic       valid;
      chan_data_t data;
   } chan_flit_t;

   // flit 0 sits in the least significant chunk
   typedef logic [core_channels_c*channel_width_c-1:0] core_word_t;

   typedef struct packed {
      logic       valid;
      core_word_t word;
   } core_msg_t;

   // sent on every output channel during the test window
   // alternating bits catch stuck and swapped wires
   localparam chan_data_t calib_pattern_c = chan_data_t'(8'ha5);

   typedef enum logic [1:0] {
      st_wait,
      st_prepare,
      st_test,
      st_done
   } calib_state_e;

   // next set bit of mask after cur, wrapping at n
   // gives back cur itself if it is the only active channel
   function automatic int unsigned next_active_f(input int unsigned cur,
                                                 input logic [31:0] mask,
                                                 input int unsigned n);
      int unsigned idx;
      int unsigned res;
      logic        found;
      res   = cur;
      found = 1'b0;
      for (int unsigned k = 1; k <= 32; k++)
      begin
         if (k <= n)
         begin
            idx = cur + k;
            if (idx >= n)
            begin
               idx = idx - n;
            end
            if (!found && mask[idx])
            begin
               res   = idx;
               found = 1'b1;
            end
         end
      end
      return res;
   endfunction

endpackage
